//--- verilog/bridge_pkg.sv
package bridge_pkg;

	// Bus word and APB address widths
	localparam int WORD_W = 32;
	localparam int APB_ADDR_W = 8;

	// First byte of a host reply
	localparam logic [7:0] REPLY_ACK = 8'h61;
	localparam logic [7:0] REPLY_NAK = 8'h6e;

	// First byte of every receive frame
	localparam logic [7:0] RX_FLAG = 8'h62;

	// APB register map
	localparam logic [APB_ADDR_W-1:0] REG_CTRL = 8'h00;
	localparam logic [APB_ADDR_W-1:0] REG_TX_OK = 8'h04;
	localparam logic [APB_ADDR_W-1:0] REG_TX_FAIL = 8'h08;
	localparam logic [APB_ADDR_W-1:0] REG_RX_MSG = 8'h0C;
	localparam logic [APB_ADDR_W-1:0] REG_TIME = 8'h10;

endpackage

//--- verilog/bridge_if.sv
`timescale 1ns/1ps

// Byte stream with valid/ready handshake
interface char_stream_if;
	logic [7:0] data;
	logic last;
	logic valid;
	logic ready;

	modport source (output data, last, valid, input ready);
	modport sink (input data, last, valid, output ready);
endinterface

// Transmit result handed from packer to arbiter
interface reply_if;
	logic req;
	logic nak;
	logic [7:0] eid;
	logic taken;

	modport source (output req, nak, eid, input taken);
	modport sink (input req, nak, eid, output taken);
endinterface

//--- verilog/tx_message_packer.sv
`timescale 1ns/1ps

module tx_message_packer (
	input logic clk,
	input logic reset,
	input logic tx_enable,
	char_stream_if.sink host,
	output logic [bridge_pkg::WORD_W-1:0] tx_addr,
	output logic [bridge_pkg::WORD_W-1:0] tx_data,
	output logic tx_pend,
	output logic tx_req,
	input logic tx_ack,
	input logic tx_succ,
	input logic tx_fail,
	output logic tx_resp_ack,
	reply_if.source reply,
	output logic tx_ok_evt,
	output logic tx_fail_evt
);
	localparam int W = bridge_pkg::WORD_W;

	typedef enum logic [2:0] {
		S_EID, S_ADDR, S_DATA, S_REQ, S_ACK_LOW, S_RESULT, S_REPLY
	} state_t;

	state_t state;
	logic [1:0] byte_cnt;
	logic [W-1:0] col_word;
	logic [7:0] eid;
	logic have_held;
	logic more_word;
	logic col_last;
	logic frame_bad;
	logic req_r;
	logic nak_r;
	logic fire;
	logic word_done;

	assign host.ready = tx_enable && (state == S_EID || state == S_ADDR || state == S_DATA);
	assign fire = host.valid & host.ready;
	assign word_done = fire & (byte_cnt == 2'd3);

	assign reply.req = req_r;
	assign reply.nak = nak_r;
	assign reply.eid = eid;
	assign tx_ok_evt = req_r & reply.taken & ~nak_r;
	assign tx_fail_evt = req_r & reply.taken & nak_r;

	// Held word sits in tx_data, the next one collects in col_word
	always_ff @(posedge clk) begin
		if (fire && state == S_EID)
			eid <= host.data;
		if (fire && state == S_ADDR)
			tx_addr <= {tx_addr[W-9:0], host.data};
		if (fire && state == S_DATA)
			col_word <= {col_word[W-9:0], host.data};
		if (word_done && state == S_DATA && !have_held)
			tx_data <= {col_word[W-9:0], host.data};
		else if (state == S_ACK_LOW && !tx_ack && more_word)
			tx_data <= col_word;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= S_EID;
			byte_cnt <= 2'd0;
			have_held <= 1'b0;
			more_word <= 1'b0;
			col_last <= 1'b0;
			frame_bad <= 1'b0;
			tx_req <= 1'b0;
			tx_pend <= 1'b0;
			tx_resp_ack <= 1'b0;
			req_r <= 1'b0;
			nak_r <= 1'b0;
		end else begin
			tx_resp_ack <= 1'b0;
			if (fire)
				byte_cnt <= byte_cnt + 2'd1;
			case (state)
				S_EID: begin
					if (fire) begin
						byte_cnt <= 2'd0;
						have_held <= 1'b0;
						frame_bad <= 1'b0;
						if (host.last) begin
							req_r <= 1'b1;
							nak_r <= 1'b1;
							state <= S_REPLY;
						end else begin
							state <= S_ADDR;
						end
					end
				end
				S_ADDR: begin
					// Frame without any data word
					if (fire && host.last) begin
						req_r <= 1'b1;
						nak_r <= 1'b1;
						state <= S_REPLY;
					end else if (fire && byte_cnt == 2'd3) begin
						state <= S_DATA;
					end
				end
				S_DATA: begin
					if (word_done) begin
						if (have_held) begin
							// Another full word follows, so the held one is pending
							tx_pend <= 1'b1;
							tx_req <= 1'b1;
							more_word <= 1'b1;
							col_last <= host.last;
							state <= S_REQ;
						end else begin
							have_held <= 1'b1;
							if (host.last) begin
								tx_pend <= 1'b0;
								tx_req <= 1'b1;
								more_word <= 1'b0;
								state <= S_REQ;
							end
						end
					end else if (fire && host.last) begin
						// Trailing partial word
						if (have_held) begin
							frame_bad <= 1'b1;
							tx_pend <= 1'b0;
							tx_req <= 1'b1;
							more_word <= 1'b0;
							state <= S_REQ;
						end else begin
							req_r <= 1'b1;
							nak_r <= 1'b1;
							state <= S_REPLY;
						end
					end
				end
				S_REQ: begin
					if (tx_ack) begin
						tx_req <= 1'b0;
						state <= more_word ? S_ACK_LOW : S_RESULT;
					end
				end
				S_ACK_LOW: begin
					if (!tx_ack) begin
						more_word <= 1'b0;
						if (col_last) begin
							tx_pend <= 1'b0;
							tx_req <= 1'b1;
							state <= S_REQ;
						end else begin
							state <= S_DATA;
						end
					end
				end
				S_RESULT: begin
					if (tx_succ || tx_fail) begin
						tx_resp_ack <= 1'b1;
						req_r <= 1'b1;
						nak_r <= tx_fail | frame_bad;
						state <= S_REPLY;
					end
				end
				S_REPLY: begin
					if (reply.taken) begin
						req_r <= 1'b0;
						state <= S_EID;
					end
				end
				default: state <= S_EID;
			endcase
		end
	end

	tx_req_held: assert property (@(posedge clk) disable iff (reset)
		tx_req && !tx_ack |=> tx_req);

	tx_word_stable: assert property (@(posedge clk) disable iff (reset)
		tx_req |=> !tx_req || ($stable(tx_addr) && $stable(tx_data) && $stable(tx_pend)));

endmodule

//--- verilog/rx_frame_builder.sv
`timescale 1ns/1ps

module rx_frame_builder (
	input logic clk,
	input logic reset,
	input logic rx_req,
	input logic [bridge_pkg::WORD_W-1:0] rx_addr,
	input logic [bridge_pkg::WORD_W-1:0] rx_data,
	input logic rx_pend,
	input logic rx_fail,
	input logic rx_bcast,
	output logic rx_ack,
	input logic [7:0] time_tag,
	char_stream_if.source frame,
	output logic rx_msg_evt
);
	localparam int W = bridge_pkg::WORD_W;

	typedef enum logic [2:0] {
		S_IDLE, S_FLAG, S_TAG, S_LOAD, S_SHIFT, S_STATUS
	} state_t;

	state_t state;
	logic [1:0] req_sync;
	logic req_s;
	logic rearm;
	logic first;
	logic pend_r;
	logic fail_acc;
	logic bcast_acc;
	logic [2:0] bytes_left;
	logic [2*W-1:0] shift_sr;
	logic [7:0] tag_r;
	logic load;
	logic fire;

	assign req_s = req_sync[1];
	// A new word only after rx_req was seen low since the last ack
	assign load = (state == S_LOAD) && req_s && rearm;
	assign fire = frame.valid & frame.ready;

	assign frame.valid = state inside {S_FLAG, S_TAG, S_SHIFT, S_STATUS};
	assign frame.last = (state == S_STATUS);
	assign rx_msg_evt = fire & frame.last;

	always_comb begin
		case (state)
			S_FLAG: frame.data = bridge_pkg::RX_FLAG;
			S_TAG: frame.data = tag_r;
			S_STATUS: frame.data = {6'd0, fail_acc, bcast_acc};
			default: frame.data = shift_sr[2*W-1 -: 8];
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && req_s && rearm)
			tag_r <= time_tag;
		if (load)
			shift_sr <= first ? {rx_addr, rx_data} : {rx_data, {W{1'b0}}};
		else if (state == S_SHIFT && fire)
			shift_sr <= {shift_sr[2*W-9:0], 8'h00};
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= S_IDLE;
			req_sync <= 2'b00;
			rearm <= 1'b1;
			rx_ack <= 1'b0;
			first <= 1'b1;
			pend_r <= 1'b0;
			fail_acc <= 1'b0;
			bcast_acc <= 1'b0;
			bytes_left <= 3'd0;
		end else begin
			req_sync <= {req_sync[0], rx_req};
			rx_ack <= load;
			if (load)
				rearm <= 1'b0;
			else if (!req_s)
				rearm <= 1'b1;
			case (state)
				S_IDLE: begin
					if (req_s && rearm) begin
						first <= 1'b1;
						fail_acc <= 1'b0;
						bcast_acc <= 1'b0;
						state <= S_FLAG;
					end
				end
				S_FLAG: if (fire) state <= S_TAG;
				S_TAG: if (fire) state <= S_LOAD;
				S_LOAD: begin
					if (load) begin
						first <= 1'b0;
						pend_r <= rx_pend;
						fail_acc <= fail_acc | rx_fail;
						bcast_acc <= bcast_acc | rx_bcast;
						// First word carries the address too
						bytes_left <= first ? 3'd7 : 3'd3;
						state <= S_SHIFT;
					end
				end
				S_SHIFT: begin
					if (fire) begin
						if (bytes_left == 3'd0)
							state <= pend_r ? S_LOAD : S_STATUS;
						else
							bytes_left <= bytes_left - 3'd1;
					end
				end
				S_STATUS: if (fire) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Every sent byte is replaced by zeros, so a drained register is all zero
	rx_ack_drained: assert property (@(posedge clk) disable iff (reset)
		rx_ack && !$past(first) |-> $past(shift_sr) == '0);

endmodule

//--- verilog/reply_arbiter.sv
`timescale 1ns/1ps

module reply_arbiter (
	input logic clk,
	input logic reset,
	reply_if.sink reply,
	char_stream_if.sink rx_frame,
	char_stream_if.source host_out
);
	typedef enum logic [1:0] {G_IDLE, G_CODE, G_EID, G_RX} grant_t;

	grant_t gnt;
	logic out_valid_r;
	logic out_last_r;
	logic [7:0] out_data_r;
	logic space;
	logic load_code;
	logic load_eid;
	logic load_rx;

	// Output register can take a byte when empty or draining
	assign space = ~out_valid_r | host_out.ready;
	assign load_code = (gnt == G_CODE) && space;
	assign load_eid = (gnt == G_EID) && space;
	assign rx_frame.ready = (gnt == G_RX) && space;
	assign load_rx = rx_frame.valid & rx_frame.ready;
	assign reply.taken = load_eid;

	assign host_out.valid = out_valid_r;
	assign host_out.data = out_data_r;
	assign host_out.last = out_last_r;

	always_ff @(posedge clk) begin
		if (load_code) begin
			out_data_r <= reply.nak ? bridge_pkg::REPLY_NAK : bridge_pkg::REPLY_ACK;
			out_last_r <= 1'b0;
		end else if (load_eid) begin
			out_data_r <= reply.eid;
			out_last_r <= 1'b1;
		end else if (load_rx) begin
			out_data_r <= rx_frame.data;
			out_last_r <= rx_frame.last;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			gnt <= G_IDLE;
			out_valid_r <= 1'b0;
		end else begin
			case (gnt)
				// Reply wins at a frame boundary
				G_IDLE: begin
					if (reply.req)
						gnt <= G_CODE;
					else if (rx_frame.valid)
						gnt <= G_RX;
				end
				G_CODE: if (space) gnt <= G_EID;
				G_EID: if (space) gnt <= G_IDLE;
				G_RX: if (load_rx && rx_frame.last) gnt <= G_IDLE;
				default: gnt <= G_IDLE;
			endcase
			if (load_code || load_eid || load_rx)
				out_valid_r <= 1'b1;
			else if (host_out.ready)
				out_valid_r <= 1'b0;
		end
	end

	host_out_hold: assert property (@(posedge clk) disable iff (reset)
		host_out.valid && !host_out.ready |=>
			host_out.valid && $stable(host_out.data) && $stable(host_out.last));

endmodule

//--- verilog/bridge_regs.sv
`timescale 1ns/1ps

module bridge_regs #(
	parameter int TIME_DIV = 16
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [bridge_pkg::APB_ADDR_W-1:0] paddr,
	input logic [bridge_pkg::WORD_W-1:0] pwdata,
	output logic [bridge_pkg::WORD_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic tx_enable,
	output logic tx_prio,
	input logic tx_ok_evt,
	input logic tx_fail_evt,
	input logic rx_msg_evt,
	output logic [7:0] time_tag
);
	localparam int DW = bridge_pkg::WORD_W;
	localparam int DIV_W = (TIME_DIV > 1) ? $clog2(TIME_DIV) : 1;

	logic [1:0] ctrl;
	logic [15:0] cnt_ok;
	logic [15:0] cnt_fail;
	logic [15:0] cnt_rx;
	logic [DIV_W-1:0] div_cnt;
	logic mapped;
	logic wr;

	assign pready = 1'b1;
	assign pslverr = psel & penable & ~mapped;
	assign wr = psel & penable & pwrite & mapped;
	assign tx_enable = ctrl[0];
	assign tx_prio = ctrl[1];

	always_comb begin
		mapped = 1'b1;
		case (paddr)
			bridge_pkg::REG_CTRL: prdata = DW'(ctrl);
			bridge_pkg::REG_TX_OK: prdata = DW'(cnt_ok);
			bridge_pkg::REG_TX_FAIL: prdata = DW'(cnt_fail);
			bridge_pkg::REG_RX_MSG: prdata = DW'(cnt_rx);
			bridge_pkg::REG_TIME: prdata = DW'(time_tag);
			default: begin
				mapped = 1'b0;
				prdata = '0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ctrl <= 2'b00;
			cnt_ok <= 16'd0;
			cnt_fail <= 16'd0;
			cnt_rx <= 16'd0;
			div_cnt <= '0;
			time_tag <= 8'd0;
		end else begin
			if (wr && paddr == bridge_pkg::REG_CTRL)
				ctrl <= pwdata[1:0];
			// Writing any value clears a counter
			if (wr && paddr == bridge_pkg::REG_TX_OK)
				cnt_ok <= 16'd0;
			else if (tx_ok_evt)
				cnt_ok <= cnt_ok + 16'd1;
			if (wr && paddr == bridge_pkg::REG_TX_FAIL)
				cnt_fail <= 16'd0;
			else if (tx_fail_evt)
				cnt_fail <= cnt_fail + 16'd1;
			if (wr && paddr == bridge_pkg::REG_RX_MSG)
				cnt_rx <= 16'd0;
			else if (rx_msg_evt)
				cnt_rx <= cnt_rx + 16'd1;
			// Time tag steps every TIME_DIV clocks
			if (div_cnt == DIV_W'(TIME_DIV - 1)) begin
				div_cnt <= '0;
				time_tag <= time_tag + 8'd1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

//--- verilog/frame_bus_bridge.sv
`timescale 1ns/1ps

module frame_bus_bridge #(
	parameter int TIME_DIV = 16
) (
	input logic clk,
	input logic reset,
	// Host byte streams
	input logic in_valid,
	output logic in_ready,
	input logic [7:0] in_data,
	input logic in_last,
	output logic out_valid,
	input logic out_ready,
	output logic [7:0] out_data,
	output logic out_last,
	// Bus transmit side
	output logic [bridge_pkg::WORD_W-1:0] tx_addr,
	output logic [bridge_pkg::WORD_W-1:0] tx_data,
	output logic tx_pend,
	output logic tx_req,
	input logic tx_ack,
	input logic tx_succ,
	input logic tx_fail,
	output logic tx_resp_ack,
	output logic tx_prio,
	// Bus receive side
	input logic rx_req,
	output logic rx_ack,
	input logic [bridge_pkg::WORD_W-1:0] rx_addr,
	input logic [bridge_pkg::WORD_W-1:0] rx_data,
	input logic rx_pend,
	input logic rx_fail,
	input logic rx_bcast,
	// APB
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [bridge_pkg::APB_ADDR_W-1:0] paddr,
	input logic [bridge_pkg::WORD_W-1:0] pwdata,
	output logic [bridge_pkg::WORD_W-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	logic tx_enable;
	logic tx_ok_evt;
	logic tx_fail_evt;
	logic rx_msg_evt;
	logic [7:0] time_tag;

	char_stream_if host_in ();
	char_stream_if rx_stream ();
	char_stream_if host_out ();
	reply_if reply ();

	assign host_in.valid = in_valid;
	assign host_in.data = in_data;
	assign host_in.last = in_last;
	assign in_ready = host_in.ready;

	assign out_valid = host_out.valid;
	assign out_data = host_out.data;
	assign out_last = host_out.last;
	assign host_out.ready = out_ready;

	tx_message_packer u_packer (
		.clk(clk), .reset(reset), .tx_enable(tx_enable), .host(host_in),
		.tx_addr(tx_addr), .tx_data(tx_data), .tx_pend(tx_pend), .tx_req(tx_req),
		.tx_ack(tx_ack), .tx_succ(tx_succ), .tx_fail(tx_fail),
		.tx_resp_ack(tx_resp_ack), .reply(reply),
		.tx_ok_evt(tx_ok_evt), .tx_fail_evt(tx_fail_evt)
	);

	rx_frame_builder u_builder (
		.clk(clk), .reset(reset), .rx_req(rx_req), .rx_addr(rx_addr), .rx_data(rx_data),
		.rx_pend(rx_pend), .rx_fail(rx_fail), .rx_bcast(rx_bcast), .rx_ack(rx_ack),
		.time_tag(time_tag), .frame(rx_stream), .rx_msg_evt(rx_msg_evt)
	);

	reply_arbiter u_arbiter (
		.clk(clk), .reset(reset), .reply(reply), .rx_frame(rx_stream), .host_out(host_out)
	);

	bridge_regs #(.TIME_DIV(TIME_DIV)) u_regs (
		.clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .tx_enable(tx_enable), .tx_prio(tx_prio),
		.tx_ok_evt(tx_ok_evt), .tx_fail_evt(tx_fail_evt), .rx_msg_evt(rx_msg_evt),
		.time_tag(time_tag)
	);

endmodule

//--- testbench/tb_frame_bus_bridge.sv
`timescale 1ns/1ps

module tb_frame_bus_bridge;
	localparam int TIMEOUT = 2000;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic [7:0] in_data;
	logic in_last;
	logic out_valid;
	logic out_ready = 1'b1;
	logic [7:0] out_data;
	logic out_last;
	logic [31:0] tx_addr;
	logic [31:0] tx_data;
	logic tx_pend;
	logic tx_req;
	logic tx_ack = 1'b0;
	logic tx_succ = 1'b0;
	logic tx_fail = 1'b0;
	logic tx_resp_ack;
	logic tx_prio;
	logic rx_req;
	logic rx_ack;
	logic [31:0] rx_addr;
	logic [31:0] rx_data;
	logic rx_pend;
	logic rx_fail;
	logic rx_bcast;
	logic psel;
	logic penable;
	logic pwrite;
	logic [bridge_pkg::APB_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	logic [15:0] lfsr = 16'd72;
	logic bp_on = 1'b0;
	logic fail_next = 1'b0;
	logic acked_pend = 1'b0;
	int ack_wait = 0;
	int result_wait = 0;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int resp_acks = 0;
	logic [8:0] out_q[$];
	logic [31:0] bus_addr_q[$];
	logic [31:0] bus_data_q[$];
	logic bus_pend_q[$];
	logic [31:0] pool[8];

	frame_bus_bridge #(.TIME_DIV(16)) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic expect_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		timeouts++;
		$display("Timed out waiting for %s at %0d ns", what, $time);
	endtask

	// Bus layer model and host output back-pressure
	always @(negedge clk) begin
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		if (reset) begin
			tx_ack = 1'b0;
			out_ready = 1'b1;
		end else begin
			out_ready = bp_on ? (rand_bits(2) != 0) : 1'b1;
			if (tx_ack && !tx_req) begin
				tx_ack = 1'b0;
				if (!acked_pend)
					result_wait = int'(rand_bits(2)) + 2;
			end else if (tx_req && !tx_ack) begin
				if (ack_wait == 0) begin
					tx_ack = 1'b1;
					acked_pend = tx_pend;
					bus_addr_q.push_back(tx_addr);
					bus_data_q.push_back(tx_data);
					bus_pend_q.push_back(tx_pend);
					ack_wait = int'(rand_bits(2));
				end else begin
					ack_wait--;
				end
			end
			if (result_wait == 1) begin
				if (fail_next)
					tx_fail = 1'b1;
				else
					tx_succ = 1'b1;
			end
			if (result_wait > 0)
				result_wait--;
		end
	end

	always @(posedge clk) begin
		if (!reset && out_valid && out_ready)
			out_q.push_back({out_last, out_data});
		if (!reset && tx_resp_ack)
			resp_acks++;
	end

	out_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
		else begin
			errors++;
			$display("** Error at %0d ns: host output byte changed while stalled", $time);
		end

	resp_ack_follows: assert property (@(posedge clk) disable iff (reset)
		tx_succ || tx_fail |=> tx_resp_ack)
		else begin
			errors++;
			$display("** Error at %0d ns: no tx_resp_ack after the bus result", $time);
		end

	host_blocked: assert property (@(posedge clk) disable iff (reset)
		tx_req |-> !in_ready)
		else begin
			errors++;
			$display("** Error at %0d ns: host bytes accepted during a bus request", $time);
		end

	rx_ack_pulse: assert property (@(posedge clk) disable iff (reset)
		rx_ack |=> !rx_ack)
		else begin
			errors++;
			$display("** Error at %0d ns: rx_ack longer than one cycle", $time);
		end

	task automatic apb_access(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int n;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		n = 0;
		@(posedge clk);
		while (!pready && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!pready)
			note_timeout("pready");
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] rd;
		logic err;
		apb_access(1'b0, addr, 32'd0, rd, err);
		expect_value(name, rd, exp);
		expect_value("pslverr", err, 1'b0);
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_access(1'b1, addr, data, rd, err);
		expect_value("pslverr", err, 1'b0);
	endtask

	task automatic read_time(output logic [7:0] t);
		logic [31:0] rd;
		logic err;
		apb_access(1'b0, bridge_pkg::REG_TIME, 32'd0, rd, err);
		t = rd[7:0];
	endtask

	task automatic drive_host_byte(input logic [7:0] b, input logic last);
		int n;
		in_valid = 1'b1;
		in_data = b;
		in_last = last;
		n = 0;
		@(posedge clk);
		while (!in_ready && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!in_ready)
			note_timeout("in_ready");
		@(negedge clk);
		in_valid = 1'b0;
		in_last = 1'b0;
	endtask

	// Event id, four address bytes, then nbytes of payload
	task automatic send_frame(input logic [7:0] eid, input logic [31:0] addr,
			input logic [31:0] w0, input logic [31:0] w1, input int nbytes);
		logic [63:0] payload;
		logic [7:0] b;
		payload = {w0, w1};
		@(negedge clk);
		for (int i = 0; i < 5 + nbytes; i++) begin
			if (i == 0)
				b = eid;
			else if (i < 5)
				b = addr[39 - 8*i -: 8];
			else
				b = payload[63 - 8*(i-5) -: 8];
			drive_host_byte(b, i == 4 + nbytes);
		end
	endtask

	task automatic send_rx_word(input logic [31:0] addr, input logic [31:0] data,
			input logic pend, input logic bcast);
		int n;
		@(negedge clk);
		rx_addr = addr;
		rx_data = data;
		rx_pend = pend;
		rx_fail = 1'b0;
		rx_bcast = bcast;
		rx_req = 1'b1;
		n = 0;
		while (!rx_ack && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!rx_ack)
			note_timeout("rx_ack");
		rx_req = 1'b0;
		// Low long enough to pass the two-flop synchronizer
		repeat (3) @(negedge clk);
	endtask

	task automatic wait_out_bytes(input int count, input string what);
		int n;
		n = 0;
		while (out_q.size() < count && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (out_q.size() < count)
			note_timeout(what);
	endtask

	task automatic check_reply(input int base, input logic nak, input logic [7:0] eid);
		if (out_q.size() < base + 2)
			return;
		expect_value("reply code", out_q[base][7:0],
			nak ? bridge_pkg::REPLY_NAK : bridge_pkg::REPLY_ACK);
		expect_value("out_last", out_q[base][8], 1'b0);
		expect_value("reply eid", out_q[base+1][7:0], eid);
		expect_value("out_last", out_q[base+1][8], 1'b1);
	endtask

	task automatic check_rx_frame(input int base, input logic [31:0] addr,
			input logic [31:0] w0, input logic [31:0] w1, input logic [7:0] status,
			input logic [7:0] t0, input logic [7:0] t1);
		logic [95:0] body;
		logic [7:0] tag;
		if (out_q.size() < base + 15)
			return;
		body = {addr, w0, w1};
		expect_value("rx flag", out_q[base][7:0], bridge_pkg::RX_FLAG);
		tag = out_q[base+1][7:0];
		checks++;
		assert (8'(tag - t0) <= 8'(t1 - t0)) else begin
			errors++;
			$display("** Error at %0d ns: time tag = 0x%0h, expected between 0x%0h and 0x%0h",
				$time, tag, t0, t1);
		end
		for (int k = 0; k < 12; k++)
			expect_value("out_data", out_q[base+2+k][7:0], body[95 - 8*k -: 8]);
		expect_value("rx status", out_q[base+14][7:0], status);
		for (int i = 0; i < 15; i++)
			expect_value("out_last", out_q[base+i][8], i == 14);
	endtask

	task automatic check_bus_words(input logic [31:0] addr, input logic [31:0] w0,
			input logic [31:0] w1, input int n);
		expect_value("bus word count", bus_data_q.size(), n);
		for (int i = 0; i < n && i < bus_data_q.size(); i++) begin
			expect_value("tx_addr", bus_addr_q[i], addr);
			expect_value("tx_data", bus_data_q[i], (i == 0) ? w0 : w1);
			expect_value("tx_pend", bus_pend_q[i], i != n - 1);
		end
		bus_addr_q.delete();
		bus_data_q.delete();
		bus_pend_q.delete();
	endtask

	initial begin
		logic [31:0] rd;
		logic err;
		logic [7:0] t0;
		logic [7:0] t1;
		int rx_base;
		int reply_base;
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = 8'd0;
		in_last = 1'b0;
		rx_req = 1'b0;
		rx_addr = '0;
		rx_data = '0;
		rx_pend = 1'b0;
		rx_fail = 1'b0;
		rx_bcast = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		for (int i = 0; i < 8; i++)
			pool[i] = rand_bits(32);
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// Register defaults, CTRL access and an unmapped offset
		expect_value("in_ready", in_ready, 1'b0);
		read_check(bridge_pkg::REG_CTRL, 32'd0, "CTRL");
		read_check(bridge_pkg::REG_TX_OK, 32'd0, "TX_OK");
		read_check(bridge_pkg::REG_TX_FAIL, 32'd0, "TX_FAIL");
		read_check(bridge_pkg::REG_RX_MSG, 32'd0, "RX_MSG");
		write_reg(bridge_pkg::REG_CTRL, 32'd2);
		read_check(bridge_pkg::REG_CTRL, 32'd2, "CTRL");
		expect_value("tx_prio", tx_prio, 1'b1);
		write_reg(bridge_pkg::REG_CTRL, 32'd1);
		read_check(bridge_pkg::REG_CTRL, 32'd1, "CTRL");
		expect_value("tx_prio", tx_prio, 1'b0);
		apb_access(1'b0, 8'h14, 32'd0, rd, err);
		expect_value("pslverr", err, 1'b1);
		apb_access(1'b1, 8'h14, 32'd3, rd, err);
		expect_value("pslverr", err, 1'b1);
		read_check(bridge_pkg::REG_CTRL, 32'd1, "CTRL");

		// Two words with bus success
		send_frame(8'h3c, pool[0], pool[1], pool[2], 8);
		wait_out_bytes(2, "ACK reply");
		check_reply(0, 1'b0, 8'h3c);
		check_bus_words(pool[0], pool[1], pool[2], 2);
		read_check(bridge_pkg::REG_TX_OK, 32'd1, "TX_OK");
		out_q.delete();

		// Two words with bus failure
		fail_next = 1'b1;
		send_frame(8'h5a, pool[3], pool[4], pool[5], 8);
		wait_out_bytes(2, "NAK reply");
		check_reply(0, 1'b1, 8'h5a);
		check_bus_words(pool[3], pool[4], pool[5], 2);
		read_check(bridge_pkg::REG_TX_FAIL, 32'd1, "TX_FAIL");
		out_q.delete();

		// One word plus a trailing partial word
		fail_next = 1'b0;
		send_frame(8'h77, pool[6], pool[7], pool[1], 6);
		wait_out_bytes(2, "NAK reply for short frame");
		check_reply(0, 1'b1, 8'h77);
		check_bus_words(pool[6], pool[7], pool[1], 1);
		read_check(bridge_pkg::REG_TX_FAIL, 32'd2, "TX_FAIL");
		out_q.delete();

		// Two-word receive message with broadcast
		read_time(t0);
		send_rx_word(pool[2], pool[4], 1'b1, 1'b1);
		send_rx_word(pool[2], pool[5], 1'b0, 1'b0);
		wait_out_bytes(15, "receive frame");
		read_time(t1);
		check_rx_frame(0, pool[2], pool[4], pool[5], 8'h01, t0, t1);
		read_check(bridge_pkg::REG_RX_MSG, 32'd1, "RX_MSG");
		out_q.delete();

		// Reply and receive frame overlapping under back-pressure
		bp_on = 1'b1;
		read_time(t0);
		fork
			send_frame(8'h21, pool[7], pool[0], pool[3], 8);
			begin
				send_rx_word(pool[1], pool[6], 1'b1, 1'b0);
				send_rx_word(pool[1], pool[2], 1'b0, 1'b1);
			end
		join
		wait_out_bytes(17, "reply and receive frame");
		read_time(t1);
		bp_on = 1'b0;
		if (out_q.size() >= 17 && out_q[0][7:0] == bridge_pkg::RX_FLAG) begin
			rx_base = 0;
			reply_base = 15;
		end else begin
			rx_base = 2;
			reply_base = 0;
		end
		check_reply(reply_base, 1'b0, 8'h21);
		check_rx_frame(rx_base, pool[1], pool[6], pool[2], 8'h01, t0, t1);
		check_bus_words(pool[7], pool[0], pool[3], 2);
		read_check(bridge_pkg::REG_TX_OK, 32'd2, "TX_OK");
		read_check(bridge_pkg::REG_RX_MSG, 32'd2, "RX_MSG");
		expect_value("tx_resp_ack pulses", resp_acks, 4);

		$display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- sources.f
verilog/bridge_pkg.sv
verilog/bridge_if.sv
verilog/tx_message_packer.sv
verilog/rx_frame_builder.sv
verilog/reply_arbiter.sv
verilog/bridge_regs.sv
verilog/frame_bus_bridge.sv
testbench/tb_frame_bus_bridge.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_frame_bus_bridge -f sources.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }
